//--- axi_addr_slice.sv
//--------------------------------------------------------------------
// One-deep register stage for an AXI3 address channel (AW or AR)
//--------------------------------------------------------------------
`default_nettype none

`include "axi_stage_settings.svh"

module axi_addr_slice (
   input  wire                         ACLK,
   input  wire                         aresetn,

   // Master side
   input  wire                         valid_m,
   input  wire axi_stage_pkg::axi_id_t    id_m,
   input  wire axi_stage_pkg::axi_addr_t  addr_m,
   input  wire axi_stage_pkg::axi_len_t   len_m,
   input  wire axi_stage_pkg::axi_size_t  size_m,
   input  wire axi_stage_pkg::axi_burst_t burst_m,
   input  wire axi_stage_pkg::axi_prot_t  prot_m,
   output logic                        ready_m,

   // Slave side
   output logic                        valid_s,
   output axi_stage_pkg::axi_id_t      id_s,
   output axi_stage_pkg::axi_addr_t    addr_s,
   output axi_stage_pkg::axi_len_t     len_s,
   output axi_stage_pkg::axi_size_t    size_s,
   output axi_stage_pkg::axi_burst_t   burst_s,
   output axi_stage_pkg::axi_prot_t    prot_s,
   input  wire                         ready_s
);

   // Previous sample of the master valid, for rise detection
   logic valid_m_q;

   //------------------------------------------------------------------
   // Valid tracking
   //------------------------------------------------------------------
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         valid_m_q <= `AXI_STAGE_VALID_RST;
         valid_s   <= `AXI_STAGE_VALID_RST;
      end else begin
         valid_m_q <= valid_m;
         // Handshake takes priority over a new request
         if (valid_s && ready_s) begin
            valid_s <= 1'b0;
         end else if (valid_m && !valid_m_q) begin
            valid_s <= 1'b1;
         end
      end
   end

   //------------------------------------------------------------------
   // Payload, re-registered every cycle
   //------------------------------------------------------------------
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         id_s    <= `AXI_STAGE_PAYLOAD_RST;
         addr_s  <= `AXI_STAGE_PAYLOAD_RST;
         len_s   <= `AXI_STAGE_PAYLOAD_RST;
         size_s  <= `AXI_STAGE_PAYLOAD_RST;
         burst_s <= `AXI_STAGE_PAYLOAD_RST;
         prot_s  <= `AXI_STAGE_PAYLOAD_RST;
      end else begin
         id_s    <= id_m;
         addr_s  <= addr_m;
         len_s   <= len_m;
         size_s  <= size_m;
         burst_s <= burst_m;
         prot_s  <= prot_m;
      end
   end

   // Master sees the handshake in the same cycle as the slave
   assign ready_m = ready_s & valid_s;

endmodule

`default_nettype wire

//--- axi_slave_stage.sv
//--------------------------------------------------------------------
// AXI3 slave-side register stage: registered AW, AR and W channels,
// B and R passed straight through
//--------------------------------------------------------------------
`default_nettype none

module axi_slave_stage (
   input  wire                          ACLK,
   input  wire                          aresetn,

   //------------------------------------------------------------------
   // Master-facing ports
   //------------------------------------------------------------------
   // Write address
   input  wire axi_stage_pkg::axi_id_t     awid_m,
   input  wire axi_stage_pkg::axi_addr_t   awaddr_m,
   input  wire axi_stage_pkg::axi_len_t    awlen_m,
   input  wire axi_stage_pkg::axi_size_t   awsize_m,
   input  wire axi_stage_pkg::axi_burst_t  awburst_m,
   input  wire axi_stage_pkg::axi_prot_t   awprot_m,
   input  wire                          awvalid_m,
   output logic                         awready_m,
   // Write data
   input  wire axi_stage_pkg::axi_id_t     wid_m,
   input  wire axi_stage_pkg::axi_data_t   wdata_m,
   input  wire axi_stage_pkg::axi_strb_t   wstrb_m,
   input  wire                          wlast_m,
   input  wire                          wvalid_m,
   output logic                         wready_m,
   // Write response
   output axi_stage_pkg::axi_id_t       bid_m,
   output axi_stage_pkg::axi_resp_t     bresp_m,
   output logic                         bvalid_m,
   input  wire                          bready_m,
   // Read address
   input  wire axi_stage_pkg::axi_id_t     arid_m,
   input  wire axi_stage_pkg::axi_addr_t   araddr_m,
   input  wire axi_stage_pkg::axi_len_t    arlen_m,
   input  wire axi_stage_pkg::axi_size_t   arsize_m,
   input  wire axi_stage_pkg::axi_burst_t  arburst_m,
   input  wire axi_stage_pkg::axi_prot_t   arprot_m,
   input  wire                          arvalid_m,
   output logic                         arready_m,
   // Read data
   output axi_stage_pkg::axi_id_t       rid_m,
   output axi_stage_pkg::axi_data_t     rdata_m,
   output axi_stage_pkg::axi_resp_t     rresp_m,
   output logic                         rlast_m,
   output logic                         rvalid_m,
   input  wire                          rready_m,

   //------------------------------------------------------------------
   // Slave-facing ports
   //------------------------------------------------------------------
   // Write address
   output axi_stage_pkg::axi_id_t       awid_s,
   output axi_stage_pkg::axi_addr_t     awaddr_s,
   output axi_stage_pkg::axi_len_t      awlen_s,
   output axi_stage_pkg::axi_size_t     awsize_s,
   output axi_stage_pkg::axi_burst_t    awburst_s,
   output axi_stage_pkg::axi_prot_t     awprot_s,
   output logic                         awvalid_s,
   input  wire                          awready_s,
   // Write data
   output axi_stage_pkg::axi_id_t       wid_s,
   output axi_stage_pkg::axi_data_t     wdata_s,
   output axi_stage_pkg::axi_strb_t     wstrb_s,
   output logic                         wlast_s,
   output logic                         wvalid_s,
   input  wire                          wready_s,
   // Write response
   input  wire axi_stage_pkg::axi_id_t     bid_s,
   input  wire axi_stage_pkg::axi_resp_t   bresp_s,
   input  wire                          bvalid_s,
   output logic                         bready_s,
   // Read address
   output axi_stage_pkg::axi_id_t       arid_s,
   output axi_stage_pkg::axi_addr_t     araddr_s,
   output axi_stage_pkg::axi_len_t      arlen_s,
   output axi_stage_pkg::axi_size_t     arsize_s,
   output axi_stage_pkg::axi_burst_t    arburst_s,
   output axi_stage_pkg::axi_prot_t     arprot_s,
   output logic                         arvalid_s,
   input  wire                          arready_s,
   // Read data
   input  wire axi_stage_pkg::axi_id_t     rid_s,
   input  wire axi_stage_pkg::axi_data_t   rdata_s,
   input  wire axi_stage_pkg::axi_resp_t   rresp_s,
   input  wire                          rlast_s,
   input  wire                          rvalid_s,
   output logic                         rready_s
);

   //------------------------------------------------------------------
   // Write address stage
   //------------------------------------------------------------------
   axi_addr_slice u_aw_slice (
      .ACLK    (ACLK),
      .aresetn (aresetn),
      .valid_m (awvalid_m),
      .id_m    (awid_m),
      .addr_m  (awaddr_m),
      .len_m   (awlen_m),
      .size_m  (awsize_m),
      .burst_m (awburst_m),
      .prot_m  (awprot_m),
      .ready_m (awready_m),
      .valid_s (awvalid_s),
      .id_s    (awid_s),
      .addr_s  (awaddr_s),
      .len_s   (awlen_s),
      .size_s  (awsize_s),
      .burst_s (awburst_s),
      .prot_s  (awprot_s),
      .ready_s (awready_s)
   );

   //------------------------------------------------------------------
   // Read address stage
   //------------------------------------------------------------------
   axi_addr_slice u_ar_slice (
      .ACLK    (ACLK),
      .aresetn (aresetn),
      .valid_m (arvalid_m),
      .id_m    (arid_m),
      .addr_m  (araddr_m),
      .len_m   (arlen_m),
      .size_m  (arsize_m),
      .burst_m (arburst_m),
      .prot_m  (arprot_m),
      .ready_m (arready_m),
      .valid_s (arvalid_s),
      .id_s    (arid_s),
      .addr_s  (araddr_s),
      .len_s   (arlen_s),
      .size_s  (arsize_s),
      .burst_s (arburst_s),
      .prot_s  (arprot_s),
      .ready_s (arready_s)
   );

   //------------------------------------------------------------------
   // Write data stage
   //------------------------------------------------------------------
   axi_wdata_slice u_w_slice (
      .ACLK     (ACLK),
      .aresetn  (aresetn),
      .wvalid_m (wvalid_m),
      .wid_m    (wid_m),
      .wdata_m  (wdata_m),
      .wstrb_m  (wstrb_m),
      .wlast_m  (wlast_m),
      .wready_m (wready_m),
      .wvalid_s (wvalid_s),
      .wid_s    (wid_s),
      .wdata_s  (wdata_s),
      .wstrb_s  (wstrb_s),
      .wlast_s  (wlast_s),
      .wready_s (wready_s)
   );

   //------------------------------------------------------------------
   // Response channels, no registers
   //------------------------------------------------------------------
   assign bid_m    = bid_s;
   assign bresp_m  = bresp_s;
   assign bvalid_m = bvalid_s;
   assign bready_s = bready_m;

   assign rid_m    = rid_s;
   assign rdata_m  = rdata_s;
   assign rresp_m  = rresp_s;
   assign rlast_m  = rlast_s;
   assign rvalid_m = rvalid_s;
   assign rready_s = rready_m;

endmodule

`default_nettype wire

//--- axi_stage_pkg.sv
//--------------------------------------------------------------------
// Field types and write-data slot state for the AXI3 register stage
//--------------------------------------------------------------------
`default_nettype none

`include "axi_stage_settings.svh"

package axi_stage_pkg;

   // Full ID as seen by the slave, master index in the upper bits
   typedef logic [`AXI_STAGE_BASE_ID_W+`AXI_STAGE_ID_W-1:0] axi_id_t;

   typedef logic [`AXI_STAGE_ADDR_W-1:0] axi_addr_t;
   typedef logic [`AXI_STAGE_DATA_W-1:0] axi_data_t;
   typedef logic [`AXI_STAGE_STRB_W-1:0] axi_strb_t;

   // AXI3 control fields, fixed by the protocol
   typedef logic [3:0] axi_len_t;
   typedef logic [2:0] axi_size_t;
   typedef logic [1:0] axi_burst_t;
   typedef logic [2:0] axi_prot_t;
   typedef logic [1:0] axi_resp_t;

   // Occupancy of the single write-data beat register
   typedef enum logic {
      slot_empty = 1'b0,
      slot_full  = 1'b1
   } wdata_slot_e;

endpackage

`default_nettype wire

//--- axi_stage_settings.svh
//--------------------------------------------------------------------
// Width and reset-value macros for the AXI3 register stage
//--------------------------------------------------------------------
`ifndef AXI_STAGE_SETTINGS_SVH
`define AXI_STAGE_SETTINGS_SVH

// Master-index bits carried in front of the transaction ID
`define AXI_STAGE_BASE_ID_W 2

// Transaction ID bits
`define AXI_STAGE_ID_W 4

// Address and data path widths
`define AXI_STAGE_ADDR_W 32
`define AXI_STAGE_DATA_W 64

// One strobe bit per data byte
`define AXI_STAGE_STRB_W 8

// Reset values of the stage registers
`define AXI_STAGE_VALID_RST 1'b0
`define AXI_STAGE_PAYLOAD_RST '0

`endif

//--- axi_wdata_slice.sv
//--------------------------------------------------------------------
// Write-data beat capture stage, holds one W beat until accepted
//--------------------------------------------------------------------
`default_nettype none

`include "axi_stage_settings.svh"

module axi_wdata_slice (
   input  wire                        ACLK,
   input  wire                        aresetn,

   // Master side
   input  wire                        wvalid_m,
   input  wire axi_stage_pkg::axi_id_t   wid_m,
   input  wire axi_stage_pkg::axi_data_t wdata_m,
   input  wire axi_stage_pkg::axi_strb_t wstrb_m,
   input  wire                        wlast_m,
   output logic                       wready_m,

   // Slave side
   output logic                       wvalid_s,
   output axi_stage_pkg::axi_id_t     wid_s,
   output axi_stage_pkg::axi_data_t   wdata_s,
   output axi_stage_pkg::axi_strb_t   wstrb_s,
   output logic                       wlast_s,
   input  wire                        wready_s
);

   import axi_stage_pkg::*;

   // Two-flop delay line on the master valid
   logic        wvalid_q1;
   logic        wvalid_q2;
   logic        wvalid_rise;
   wdata_slot_e slot_q;

   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         wvalid_q1 <= `AXI_STAGE_VALID_RST;
         wvalid_q2 <= `AXI_STAGE_VALID_RST;
      end else begin
         wvalid_q1 <= wvalid_m;
         wvalid_q2 <= wvalid_q1;
      end
   end

   // Rise seen between the delayed copies, one cycle after first sample
   assign wvalid_rise = wvalid_q1 & ~wvalid_q2;

   //------------------------------------------------------------------
   // Beat slot
   //------------------------------------------------------------------
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         slot_q  <= slot_empty;
         wid_s   <= `AXI_STAGE_PAYLOAD_RST;
         wdata_s <= `AXI_STAGE_PAYLOAD_RST;
         wstrb_s <= `AXI_STAGE_PAYLOAD_RST;
         wlast_s <= `AXI_STAGE_VALID_RST;
      end else begin
         if (slot_q == slot_full && wready_s) begin
            // Beat taken by the slave, data left as is
            slot_q  <= slot_empty;
            wlast_s <= 1'b0;
         end else if (wvalid_rise) begin
            slot_q  <= slot_full;
            wid_s   <= wid_m;
            wdata_s <= wdata_m;
            wstrb_s <= wstrb_m;
            wlast_s <= wlast_m;
         end
      end
   end

   assign wvalid_s = (slot_q == slot_full);

   // Ready back to the master only while a beat is offered
   assign wready_m = wready_s & wvalid_s;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI3 register stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_sim

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_axi_slave_stage \
   --Mdir "$OBJ" -o "$BIN" \
   -f vlog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi

echo "Pass message not found in $LOG"
exit 1

//--- tb_axi_slave_stage.sv
//--------------------------------------------------------------------
// Testbench for the AXI3 register stage with a stimulus table, LFSR
// stalls, latency, back-pressure and response pass-through checks
//--------------------------------------------------------------------
`default_nettype none

module tb_axi_slave_stage;

   timeunit 1ns;
   timeprecision 1ps;

   import axi_stage_pkg::*;

   typedef enum logic [1:0] {ch_aw, ch_ar, ch_w} chan_e;

   // One table row whose payload fields double as expected values
   typedef struct {
      chan_e      chan;
      axi_id_t    id;
      axi_addr_t  addr;
      axi_len_t   len;
      axi_size_t  size;
      axi_burst_t burst;
      axi_prot_t  prot;
      axi_data_t  data;
      axi_strb_t  strb;
      logic       last;
      int         stall;
   } stim_row_t;

   localparam int num_rows    = 12;
   localparam int stall_bits  = 3;
   localparam int stall_max   = (1 << stall_bits) - 1;
   localparam int resp_rounds = 6;
   localparam int cycle_limit = num_rows * (stall_max + 6) + 50;

   logic       ACLK;
   logic       aresetn;
   axi_id_t    awid_m, awid_s, arid_m, arid_s, wid_m, wid_s;
   axi_id_t    bid_m, bid_s, rid_m, rid_s;
   axi_addr_t  awaddr_m, awaddr_s, araddr_m, araddr_s;
   axi_len_t   awlen_m, awlen_s, arlen_m, arlen_s;
   axi_size_t  awsize_m, awsize_s, arsize_m, arsize_s;
   axi_burst_t awburst_m, awburst_s, arburst_m, arburst_s;
   axi_prot_t  awprot_m, awprot_s, arprot_m, arprot_s;
   axi_data_t  wdata_m, wdata_s, rdata_m, rdata_s;
   axi_strb_t  wstrb_m, wstrb_s;
   axi_resp_t  bresp_m, bresp_s, rresp_m, rresp_s;
   logic       awvalid_m, awready_m, awvalid_s, awready_s;
   logic       arvalid_m, arready_m, arvalid_s, arready_s;
   logic       wvalid_m, wready_m, wvalid_s, wready_s, wlast_m, wlast_s;
   logic       bvalid_m, bready_m, bvalid_s, bready_s;
   logic       rvalid_m, rready_m, rvalid_s, rready_s, rlast_m, rlast_s;

   stim_row_t   rows [num_rows];
   logic [31:0] lfsr_state;
   int          cycle_count = 0;

   tb_clock_gen u_clock_gen (.ACLK(ACLK), .aresetn(aresetn));

   axi_slave_stage i_axi_slave_stage (.*);

   //------------------------------------------------------------------
   // Galois LFSR with taps 32, 22, 2 and 1
   //------------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 32'h8020_0003;
      end
      return next;
   endfunction

   function automatic logic [63:0] draw_bits(input int n);
      logic [63:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         value = {value[62:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return value;
   endfunction

   task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   //------------------------------------------------------------------
   // Channel access
   //------------------------------------------------------------------
   function automatic logic slave_valid(input chan_e chan);
      case (chan)
         ch_aw:   return awvalid_s;
         ch_ar:   return arvalid_s;
         default: return wvalid_s;
      endcase
   endfunction

   function automatic logic master_ready(input chan_e chan);
      case (chan)
         ch_aw:   return awready_m;
         ch_ar:   return arready_m;
         default: return wready_m;
      endcase
   endfunction

   function automatic logic [127:0] slave_payload(input chan_e chan);
      case (chan)
         ch_aw:   return 128'({awid_s, awaddr_s, awlen_s, awsize_s, awburst_s, awprot_s});
         ch_ar:   return 128'({arid_s, araddr_s, arlen_s, arsize_s, arburst_s, arprot_s});
         default: return 128'({wid_s, wdata_s, wstrb_s, wlast_s});
      endcase
   endfunction

   // Slave side must show the fields exactly as the master gave them
   function automatic logic [127:0] row_payload(input stim_row_t row);
      if (row.chan == ch_w) begin
         return 128'({row.id, row.data, row.strb, row.last});
      end
      return 128'({row.id, row.addr, row.len, row.size, row.burst, row.prot});
   endfunction

   task automatic drive_request(input stim_row_t row, input logic valid);
      case (row.chan)
         ch_aw: begin
            {awid_m, awaddr_m, awlen_m, awsize_m, awburst_m, awprot_m} =
               {row.id, row.addr, row.len, row.size, row.burst, row.prot};
            awvalid_m = valid;
         end
         ch_ar: begin
            {arid_m, araddr_m, arlen_m, arsize_m, arburst_m, arprot_m} =
               {row.id, row.addr, row.len, row.size, row.burst, row.prot};
            arvalid_m = valid;
         end
         default: begin
            {wid_m, wdata_m, wstrb_m, wlast_m} = {row.id, row.data, row.strb, row.last};
            wvalid_m = valid;
         end
      endcase
   endtask

   task automatic set_slave_ready(input chan_e chan, input logic ready);
      case (chan)
         ch_aw:   awready_s = ready;
         ch_ar:   arready_s = ready;
         default: wready_s = ready;
      endcase
   endtask

   // Inputs change 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge ACLK);
      #2;
   endtask

   task automatic init_inputs();
      {awid_m, awaddr_m, awlen_m, awsize_m, awburst_m, awprot_m, awvalid_m} = '0;
      {arid_m, araddr_m, arlen_m, arsize_m, arburst_m, arprot_m, arvalid_m} = '0;
      {wid_m, wdata_m, wstrb_m, wlast_m, wvalid_m, bready_m, rready_m} = '0;
      {awready_s, arready_s, wready_s, bid_s, bresp_s, bvalid_s} = '0;
      {rid_s, rdata_s, rresp_s, rlast_s, rvalid_s} = '0;
   endtask

   //------------------------------------------------------------------
   // Stimulus table
   //------------------------------------------------------------------
   task automatic fill_table();
      rows[0]  = '{ch_aw, 6'h05, 32'h0000_1000, 4'h3, 3'h2, 2'b01, 3'h0, '0, '0, 1'b0, 0};
      rows[1]  = '{ch_w, 6'h05, '0, '0, '0, '0, '0, 64'h0123_4567_89ab_cdef, 8'hff, 1'b0, 0};
      rows[2]  = '{ch_ar, 6'h2a, 32'hdead_beec, 4'hf, 3'h3, 2'b10, 3'h5, '0, '0, 1'b0, 0};
      rows[3]  = '{ch_w, 6'h05, '0, '0, '0, '0, '0, 64'hfedc_ba98_7654_3210, 8'h0f, 1'b1, 0};
      rows[4]  = '{ch_aw, 6'h3f, 32'hffff_fff0, 4'h0, 3'h0, 2'b00, 3'h7, '0, '0, 1'b0, 0};
      rows[5]  = '{ch_ar, 6'h11, 32'h8000_0040, 4'h7, 3'h1, 2'b01, 3'h2, '0, '0, 1'b0, 0};
      rows[6]  = '{ch_w, 6'h3f, '0, '0, '0, '0, '0, 64'h5555_aaaa_0f0f_f0f0, 8'h81, 1'b1, 0};
      rows[7]  = '{ch_w, 6'h20, '0, '0, '0, '0, '0, 64'h0000_0000_0000_0001, 8'h01, 1'b1, 0};
      rows[8]  = '{ch_ar, 6'h00, 32'h0000_0000, 4'h1, 3'h3, 2'b11, 3'h1, '0, '0, 1'b0, 0};
      rows[9]  = '{ch_aw, 6'h20, 32'h1234_5678, 4'h8, 3'h2, 2'b10, 3'h4, '0, '0, 1'b0, 0};
      rows[10] = '{ch_w, 6'h20, '0, '0, '0, '0, '0, 64'hffff_ffff_ffff_ffff, 8'hf0, 1'b1, 0};
      rows[11] = '{ch_ar, 6'h15, 32'h4000_0ff8, 4'h2, 3'h3, 2'b01, 3'h6, '0, '0, 1'b0, 0};
      for (int i = 0; i < num_rows; i++) begin
         rows[i].stall = int'(draw_bits(stall_bits));
      end
   endtask

   task automatic check_idle(input string when);
      check_equal(128'(awvalid_s), 128'd0, {when, " awvalid_s"});
      check_equal(128'(arvalid_s), 128'd0, {when, " arvalid_s"});
      check_equal(128'(wvalid_s), 128'd0, {when, " wvalid_s"});
      check_equal(slave_payload(ch_aw), 128'd0, {when, " AW payload"});
      check_equal(slave_payload(ch_ar), 128'd0, {when, " AR payload"});
      check_equal(slave_payload(ch_w), 128'd0, {when, " W payload"});
   endtask

   // Address valid shows up one cycle after the request is driven and W valid two
   task automatic apply_row(input int idx);
      stim_row_t row;
      int        lat;
      row = rows[idx];
      lat = (row.chan == ch_w) ? 2 : 1;
      next_cycle();
      drive_request(row, 1'b1);
      set_slave_ready(row.chan, 1'b0);
      for (int c = 1; c < lat; c++) begin
         next_cycle();
         #1;
         check_equal(128'(slave_valid(row.chan)), 128'd0, $sformatf("row %0d early valid", idx));
      end
      // Slave stalls and then raises ready
      for (int s = 0; s <= row.stall; s++) begin
         next_cycle();
         set_slave_ready(row.chan, s == row.stall);
         #1;
         check_equal(128'(slave_valid(row.chan)), 128'd1, $sformatf("row %0d valid_s", idx));
         check_equal(128'(master_ready(row.chan)), 128'(s == row.stall),
                     $sformatf("row %0d ready_m, stall cycle %0d", idx, s));
         check_equal(slave_payload(row.chan), row_payload(row),
                     $sformatf("row %0d payload", idx));
      end
      // Handshake edge has passed and slave ready stays high with nothing offered
      next_cycle();
      drive_request(row, 1'b0);
      #1;
      check_equal(128'(slave_valid(row.chan)), 128'd0, $sformatf("row %0d valid after xfer", idx));
      check_equal(128'(master_ready(row.chan)), 128'd0,
                  $sformatf("row %0d ready_m without valid_s", idx));
   endtask

   task automatic check_responses(input int round);
      logic [9:0]  b_exp;
      logic [74:0] r_exp;
      next_cycle();
      b_exp = 10'(draw_bits(10));
      r_exp = {11'(draw_bits(11)), draw_bits(64)};
      {bid_s, bresp_s, bvalid_s, bready_m} = b_exp;
      {rid_s, rdata_s, rresp_s, rlast_s, rvalid_s, rready_m} = r_exp;
      #1;
      check_equal(128'({bid_m, bresp_m, bvalid_m, bready_s}), 128'(b_exp),
                  $sformatf("round %0d B pass-through", round));
      check_equal(128'({rid_m, rdata_m, rresp_m, rlast_m, rvalid_m, rready_s}), 128'(r_exp),
                  $sformatf("round %0d R pass-through", round));
   endtask

   always @(posedge ACLK) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("ERROR: run did not finish within %0d clock cycles", cycle_limit);
         $display("STATUS: FAIL");
         $fatal(1, "Timeout");
      end
   end

   initial begin
      lfsr_state = 32'h1448_6a65;
      init_inputs();
      fill_table();
      @(posedge ACLK);
      #3;
      check_idle("in reset");
      wait (aresetn === 1'b1);
      @(posedge ACLK);
      #3;
      check_idle("after reset");
      for (int i = 0; i < num_rows; i++) begin
         apply_row(i);
      end
      for (int i = 0; i < resp_rounds; i++) begin
         check_responses(i);
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
//--------------------------------------------------------------------
// Testbench clock (20 ns period) and active-low reset source
//--------------------------------------------------------------------
`default_nettype none

module tb_clock_gen (
   output logic ACLK,
   output logic aresetn
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      ACLK = 1'b0;
   end

   always #10 ACLK = ~ACLK;

   // Reset held for two rising edges, released just after the second
   initial begin
      aresetn = 1'b0;
      repeat (2) @(posedge ACLK);
      #2;
      aresetn = 1'b1;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
axi_stage_pkg.sv
axi_addr_slice.sv
axi_wdata_slice.sv
axi_slave_stage.sv
tb_clock_gen.sv
tb_axi_slave_stage.sv
